// File: source/ipcell_defines.svh
// Sizing macros for the inner-product cell, included by the packages and the testbench
`ifndef IPCELL_DEFINES_SVH
`define IPCELL_DEFINES_SVH

// ------------------------------------------------------------
// Element and bus sizing
// ------------------------------------------------------------
`define IPCELL_ELEM_BITS   8   // Signed int8 element
`define IPCELL_DWD_ELEMS   4   // Vertical bus carries y0..y3
`define IPCELL_FWD_ELEMS   2   // Horizontal bus carries x0, x1

// ------------------------------------------------------------
// Arithmetic sizing
// ------------------------------------------------------------
`define IPCELL_ACC_BITS    32  // Accumulator and backward chain width
`define IPCELL_MUL_STAGES  3   // mul_en beats from operand reg to product reg

`endif

// File: source/ipcell_cmd_pkg.sv
// Command word carried along the cell row, with the valid-bit gating used at each cell input
package ipcell_cmd_pkg;

  // Packed in the order the row bus carries it, mul_enable is the MSB
  typedef struct packed {
    logic mul_enable;  // Advance the multiply pipeline
    logic acc_enable;  // Add products into the accumulators
    logic acc_afresh;  // Clear both accumulators
    logic drain_req0;  // Move accumulator 1 into accumulator 0
    logic drain_req1;  // Push accumulator 0 onto the backward chain
  } ipcell_cmd_t;

  // Arithmetic bits follow the data valid, drain bits follow the drain valid
  function automatic ipcell_cmd_t ipcell_cmd_gate(input ipcell_cmd_t cmd,
                                                  input logic        arith_vld,
                                                  input logic        drain_vld);
    ipcell_cmd_t gated;
    gated.mul_enable = cmd.mul_enable & arith_vld;
    gated.acc_enable = cmd.acc_enable & arith_vld;
    gated.acc_afresh = cmd.acc_afresh & arith_vld;
    gated.drain_req0 = cmd.drain_req0 & drain_vld;
    gated.drain_req1 = cmd.drain_req1 & drain_vld;
    return gated;
  endfunction

endpackage

// File: source/ipcell_num_pkg.sv
// Numeric types of the inner-product cell: elements, buses, pre-add sums, products, accumulators
`include "ipcell_defines.svh"

package ipcell_num_pkg;

  // ------------------------------------------------------------
  // Operand types
  // ------------------------------------------------------------
  typedef logic signed [`IPCELL_ELEM_BITS-1:0] elem_t;      // One int8 element

  typedef elem_t [`IPCELL_DWD_ELEMS-1:0] dwd_dat_t;         // y3..y0, y0 in the low byte
  typedef elem_t [`IPCELL_FWD_ELEMS-1:0] fwd_dat_t;         // x1..x0, x0 in the low byte

  // ------------------------------------------------------------
  // Arithmetic types
  // ------------------------------------------------------------
  // Sum of two int8 needs one extra bit
  typedef logic signed [`IPCELL_ELEM_BITS:0] psum_t;

  // Product of two pre-add sums, 9x9 signed
  typedef logic signed [2*(`IPCELL_ELEM_BITS+1)-1:0] prod_t;

  // Running sum, also the width of the backward chain
  typedef logic signed [`IPCELL_ACC_BITS-1:0] acc_t;

endpackage

// File: source/ipcell_op_if.sv
// Registered operands and gated command from the forwarding stage to the multiply and accumulate blocks
`timescale 1ns/1ps

interface ipcell_op_if
  import ipcell_num_pkg::*;
();

  elem_t x0;      // Horizontal element 0
  elem_t x1;      // Horizontal element 1
  elem_t y0;      // Vertical elements
  elem_t y1;
  elem_t y2;
  elem_t y3;

  logic  mul_en;  // Stored mul_enable
  logic  acc_en;  // Stored acc_enable
  logic  afresh;  // Stored acc_afresh
  logic  move;    // Stored drain_req0, lane1 to lane0
  logic  drain;   // Stored drain_req1, onto the chain

  // Forwarding stage owns every signal
  modport src     (output x0, x1, y0, y1, y2, y3, mul_en, acc_en, afresh, move, drain);

  // Multiply pipeline sees operands and its stage enable
  modport mul_snk (input  x0, x1, y0, y1, y2, y3, mul_en);

  // Accumulators see only the accumulate and drain controls
  modport acc_snk (input  acc_en, afresh, move, drain);

endinterface

// File: source/ipcell_fwd_stage.sv
// Gates the row command with the valid bits and registers data and command for the neighbour cells
`timescale 1ns/1ps

module ipcell_fwd_stage
  import ipcell_num_pkg::*;
  import ipcell_cmd_pkg::*;
(
  input  logic        aixh_core_clk2x,
  input  logic        i_rst,

  // Vertical bus
  input  logic [1:0]  i_dwd_vld,   // [0] data and arithmetic, [1] drain
  input  dwd_dat_t    i_dwd_dat,
  output logic [1:0]  o_dwd_vld,
  output dwd_dat_t    o_dwd_dat,

  // Horizontal bus
  input  ipcell_cmd_t i_fwd_cmd,
  input  fwd_dat_t    i_fwd_dat,
  output ipcell_cmd_t o_fwd_cmd,
  output fwd_dat_t    o_fwd_dat,

  ipcell_op_if.src    op           // Same registers, toward the arithmetic
);

  ipcell_cmd_t cmd_gated;          // Command after valid gating

  // ------------------------------------------------------------
  // Command gating
  // ------------------------------------------------------------
  assign cmd_gated = ipcell_cmd_gate(i_fwd_cmd, i_dwd_vld[0], i_dwd_vld[1]);

  // ------------------------------------------------------------
  // Inter-cell pipeline
  // ------------------------------------------------------------
  always_ff @(posedge aixh_core_clk2x) begin
    if (i_rst) begin
      o_dwd_vld <= 2'b00;
      o_fwd_cmd <= '0;
    end else begin
      o_dwd_vld <= i_dwd_vld;      // Valids pass every cycle
      o_fwd_cmd <= cmd_gated;
    end
  end

  // Data holds between valid beats so idle cycles do not toggle the row
  always_ff @(posedge aixh_core_clk2x) begin
    if (i_dwd_vld[0]) begin
      o_dwd_dat <= i_dwd_dat;
      o_fwd_dat <= i_fwd_dat;
    end
  end

  // ------------------------------------------------------------
  // Operand view for the arithmetic
  // ------------------------------------------------------------
  assign op.x0     = o_fwd_dat[0];
  assign op.x1     = o_fwd_dat[1];
  assign op.y0     = o_dwd_dat[0];
  assign op.y1     = o_dwd_dat[1];
  assign op.y2     = o_dwd_dat[2];
  assign op.y3     = o_dwd_dat[3];

  assign op.mul_en = o_fwd_cmd.mul_enable;
  assign op.acc_en = o_fwd_cmd.acc_enable;
  assign op.afresh = o_fwd_cmd.acc_afresh;
  assign op.move   = o_fwd_cmd.drain_req0;
  assign op.drain  = o_fwd_cmd.drain_req1;

  // Row controller sends a move only together with accumulate
  a_move_has_acc: assert property (
    @(posedge aixh_core_clk2x) disable iff (i_rst)
      o_fwd_cmd.drain_req0 |-> o_fwd_cmd.acc_enable
  ) else $error("stored move without accumulate enable");

endmodule

// File: source/ipcell_mul_pair.sv
// Two-lane pre-add and multiply pipeline, lane0 = (x0+y1)*(x1+y0), lane1 = (x0+y3)*(x1+y2)
`timescale 1ns/1ps

module ipcell_mul_pair
  import ipcell_num_pkg::*;
(
  input  logic        aixh_core_clk2x,
  input  logic        i_rst,

  ipcell_op_if.mul_snk op,         // Registered operands and mul_en

  output prod_t       o_prod0,     // Lane0 product register
  output prod_t       o_prod1      // Lane1 product register
);

  // ------------------------------------------------------------
  // Stage registers
  // ------------------------------------------------------------
  psum_t s1_usum0;                 // x0 + y1
  psum_t s1_usum1;                 // x0 + y3
  elem_t s1_x1;                    // Held for the second pre-add
  elem_t s1_y0;
  elem_t s1_y2;

  psum_t s2_usum0;                 // Delayed to meet the v sums
  psum_t s2_usum1;
  psum_t s2_vsum0;                 // x1 + y0
  psum_t s2_vsum1;                 // x1 + y2

  // Whole pipe stalls together, so items in flight keep their order
  always_ff @(posedge aixh_core_clk2x) begin
    if (i_rst) begin
      s1_usum0 <= '0;
      s1_usum1 <= '0;
      s1_x1    <= '0;
      s1_y0    <= '0;
      s1_y2    <= '0;
      s2_usum0 <= '0;
      s2_usum1 <= '0;
      s2_vsum0 <= '0;
      s2_vsum1 <= '0;
      o_prod0  <= '0;
      o_prod1  <= '0;
    end else if (op.mul_en) begin
      // Stage 1, shared x0 against y1 and y3
      s1_usum0 <= psum_t'(op.x0) + psum_t'(op.y1);
      s1_usum1 <= psum_t'(op.x0) + psum_t'(op.y3);
      s1_x1    <= op.x1;
      s1_y0    <= op.y0;
      s1_y2    <= op.y2;

      // Stage 2, shared x1 against y0 and y2
      s2_usum0 <= s1_usum0;
      s2_usum1 <= s1_usum1;
      s2_vsum0 <= psum_t'(s1_x1) + psum_t'(s1_y0);
      s2_vsum1 <= psum_t'(s1_x1) + psum_t'(s1_y2);

      // Stage 3, 9x9 signed multiply
      o_prod0  <= s2_usum0 * s2_vsum0;
      o_prod1  <= s2_usum1 * s2_vsum1;
    end
  end

endmodule

// File: source/ipcell_accum_drain.sv
// Lane accumulators with clear and lane1-to-lane0 move, and the registered backward drain chain
`timescale 1ns/1ps

module ipcell_accum_drain
  import ipcell_num_pkg::*;
(
  input  logic        aixh_core_clk2x,
  input  logic        i_rst,

  input  prod_t       i_prod0,     // From the multiply pipe
  input  prod_t       i_prod1,

  ipcell_op_if.acc_snk op,         // acc_en, afresh, move, drain

  // Backward chain, neighbour side and toward the row end
  input  logic        i_bwd_vld,
  input  acc_t        i_bwd_dat,
  output logic        o_bwd_vld,
  output acc_t        o_bwd_dat
);

  acc_t acc0;                      // Lane0 sum, the value that drains
  acc_t acc1;                      // Lane1 sum, reaches the chain through acc0
  logic bwd_take;                  // Chain register loads this cycle

  // ------------------------------------------------------------
  // Accumulators
  // ------------------------------------------------------------
  always_ff @(posedge aixh_core_clk2x) begin
    if (i_rst) begin
      acc0 <= '0;
      acc1 <= '0;
    end else if (op.afresh) begin
      acc0 <= '0;                  // Clear wins over enable and move
      acc1 <= '0;
    end else if (op.acc_en) begin
      acc1 <= acc1 + acc_t'(i_prod1);
      if (op.move) begin
        acc0 <= acc1;              // Lane1 result lines up behind lane0
      end else begin
        acc0 <= acc0 + acc_t'(i_prod0);
      end
    end
  end

  // ------------------------------------------------------------
  // Drain
  // ------------------------------------------------------------
  assign bwd_take = op.drain | i_bwd_vld;

  always_ff @(posedge aixh_core_clk2x) begin
    if (i_rst) begin
      o_bwd_vld <= 1'b0;
    end else begin
      o_bwd_vld <= bwd_take;
    end
  end

  // Upstream results pass first, a local drain in the same cycle is lost
  always_ff @(posedge aixh_core_clk2x) begin
    if (bwd_take) begin
      o_bwd_dat <= i_bwd_vld ? i_bwd_dat : acc0;
    end
  end

  // Row controller never asks for a clear and a move on the same beat
  a_afresh_no_move: assert property (
    @(posedge aixh_core_clk2x) disable iff (i_rst)
      !(op.afresh && op.move)
  ) else $error("afresh and move stored together");

endmodule

// File: source/ipcell_top.sv
// Inner-product cell top level, one tile of the systolic array with plain neighbour ports
`timescale 1ns/1ps

module ipcell_top
  import ipcell_num_pkg::*;
  import ipcell_cmd_pkg::*;
(
  input  logic        aixh_core_clk2x,
  input  logic        i_rst,

  // ------------------------------------------------------------
  // Vertical interface, from the cell above to the cell below
  // ------------------------------------------------------------
  input  logic [1:0]  i_dwd_vld,   // [0] data, [1] drain
  input  dwd_dat_t    i_dwd_dat,
  output logic [1:0]  o_dwd_vld,
  output dwd_dat_t    o_dwd_dat,

  // ------------------------------------------------------------
  // Horizontal interface, from the left cell to the right cell
  // ------------------------------------------------------------
  input  ipcell_cmd_t i_fwd_cmd,
  input  fwd_dat_t    i_fwd_dat,
  output ipcell_cmd_t o_fwd_cmd,
  output fwd_dat_t    o_fwd_dat,

  // ------------------------------------------------------------
  // Backward chain, results flow against the command
  // ------------------------------------------------------------
  input  logic        i_bwd_vld,
  input  acc_t        i_bwd_dat,
  output logic        o_bwd_vld,
  output acc_t        o_bwd_dat
);

  prod_t prod0;                    // Lane0 product into acc0
  prod_t prod1;                    // Lane1 product into acc1

  ipcell_op_if u_op_if ();         // Operands and gated command

  // Gating and neighbour registers
  ipcell_fwd_stage u_fwd_stage (
    .aixh_core_clk2x (aixh_core_clk2x),
    .i_rst           (i_rst),
    .i_dwd_vld       (i_dwd_vld),
    .i_dwd_dat       (i_dwd_dat),
    .o_dwd_vld       (o_dwd_vld),
    .o_dwd_dat       (o_dwd_dat),
    .i_fwd_cmd       (i_fwd_cmd),
    .i_fwd_dat       (i_fwd_dat),
    .o_fwd_cmd       (o_fwd_cmd),
    .o_fwd_dat       (o_fwd_dat),
    .op              (u_op_if.src)
  );

  // Three-stage pre-add and multiply
  ipcell_mul_pair u_mul_pair (
    .aixh_core_clk2x (aixh_core_clk2x),
    .i_rst           (i_rst),
    .op              (u_op_if.mul_snk),
    .o_prod0         (prod0),
    .o_prod1         (prod1)
  );

  // Accumulate and drain
  ipcell_accum_drain u_accum_drain (
    .aixh_core_clk2x (aixh_core_clk2x),
    .i_rst           (i_rst),
    .i_prod0         (prod0),
    .i_prod1         (prod1),
    .op              (u_op_if.acc_snk),
    .i_bwd_vld       (i_bwd_vld),
    .i_bwd_dat       (i_bwd_dat),
    .o_bwd_vld       (o_bwd_vld),
    .o_bwd_dat       (o_bwd_dat)
  );

endmodule

// File: verif/tb_clk_gen.sv
// Testbench clock and reset source, 10 ns clock with reset held high for the first five cycles
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_NS    = 5,    // Half period, 10 ns clock
  parameter int RST_CYCLES = 5     // Rising edges seen with reset high
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_NS o_clk = ~o_clk;
  end

  // Release on a falling edge, same edge the stimulus uses
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(negedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

// File: verif/tb_ipcell.sv
// Self-checking testbench for the inner-product cell, random tiles, drain, move, priority and gating
`timescale 1ns/1ps
`include "ipcell_defines.svh"

module tb_ipcell
  import ipcell_num_pkg::*;
  import ipcell_cmd_pkg::*;
();

  localparam int          NUM_TILES = 6;
  localparam int          MAX_K     = 16;
  localparam int          FLUSH     = `IPCELL_MUL_STAGES;  // Zero beats that empty the pipe
  localparam logic [31:0] LFSR_SEED = 32'h4d49_9c35;

  logic        aixh_core_clk2x;
  logic        rst;
  logic [1:0]  dwd_vld;
  dwd_dat_t    dwd_dat;
  ipcell_cmd_t fwd_cmd;
  fwd_dat_t    fwd_dat;
  logic        bwd_vld;
  acc_t        bwd_dat;
  logic [1:0]  o_dwd_vld;
  dwd_dat_t    o_dwd_dat;
  ipcell_cmd_t o_fwd_cmd;
  fwd_dat_t    o_fwd_dat;
  logic        o_bwd_vld;
  acc_t        o_bwd_dat;

  logic [31:0] lfsr;                                    // Galois LFSR state
  elem_t       tx0 [MAX_K];                             // Stimulus of the running tile
  elem_t       tx1 [MAX_K];
  elem_t       ty0 [MAX_K];
  elem_t       ty1 [MAX_K];
  elem_t       ty2 [MAX_K];
  elem_t       ty3 [MAX_K];
  logic        exp_en;                                  // Beat carries a chain result
  acc_t        exp_val;
  acc_t        exp_q [$];                               // Chain results in output order
  logic        rec_active;                              // Monitor state, written at posedge
  logic [1:0]  rec_vld;
  ipcell_cmd_t rec_cmd;
  dwd_dat_t    rec_dwd;
  fwd_dat_t    rec_fwd;
  logic        dat_known;
  logic        drain_d1;
  logic        rec_bvld;
  int          cycles;
  int          limit;
  int          checks;
  int          errors;

  tb_clk_gen u_clk_gen (.o_clk(aixh_core_clk2x), .o_rst(rst));

  ipcell_top i_dut (
    .aixh_core_clk2x (aixh_core_clk2x),
    .i_rst           (rst),
    .i_dwd_vld       (dwd_vld),
    .i_dwd_dat       (dwd_dat),
    .o_dwd_vld       (o_dwd_vld),
    .o_dwd_dat       (o_dwd_dat),
    .i_fwd_cmd       (fwd_cmd),
    .i_fwd_dat       (fwd_dat),
    .o_fwd_cmd       (o_fwd_cmd),
    .o_fwd_dat       (o_fwd_dat),
    .i_bwd_vld       (bwd_vld),
    .i_bwd_dat       (bwd_dat),
    .o_bwd_vld       (o_bwd_vld),
    .o_bwd_dat       (o_bwd_dat)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v    = {v[30:0], lfsr[0]};                        // One LFSR step per bit
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic ipcell_cmd_t mk_cmd(input logic mul, input logic acc, input logic afresh,
                                         input logic move, input logic drain);
    ipcell_cmd_t c;
    c.mul_enable = mul;
    c.acc_enable = acc;
    c.acc_afresh = afresh;
    c.drain_req0 = move;
    c.drain_req1 = drain;
    return c;
  endfunction

  // Three arithmetic bits follow vld[0], two drain bits follow vld[1]
  function automatic ipcell_cmd_t expect_gated(input ipcell_cmd_t c, input logic [1:0] v);
    logic [4:0] mask;
    mask = {{3{v[0]}}, {2{v[1]}}};
    return c & mask;
  endfunction

  // Lane0 (x0+y1)*(x1+y0), lane1 (x0+y3)*(x1+y2), summed over the tile
  function automatic acc_t ref_lane_sum(input int lane, input int k);
    int u;
    int v;
    int s;
    s = 0;
    for (int i = 0; i < k; i++) begin
      u = int'(tx0[i]) + ((lane == 0) ? int'(ty1[i]) : int'(ty3[i]));
      v = int'(tx1[i]) + ((lane == 0) ? int'(ty0[i]) : int'(ty2[i]));
      s += u * v;
    end
    return acc_t'(s);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] want, input logic [31:0] got);
    $display("[FAIL] t=%0t %s expected 0x%h actual 0x%h", $time, name, want, got);
    errors += 1;
  endtask

  task automatic report_problem(input string msg);
    $display("[ERROR] t=%0t %s", $time, msg);
    errors += 1;
  endtask

  task automatic finish_run();
    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // Inputs change on the falling edge, then wait one cycle
  task automatic apply_beat(input logic [1:0] vld, input ipcell_cmd_t cmd, input dwd_dat_t dwd,
                            input fwd_dat_t fwd, input logic bvld, input acc_t bdat,
                            input logic xen, input acc_t xval);
    dwd_vld = vld;
    fwd_cmd = cmd;
    dwd_dat = dwd;
    fwd_dat = fwd;
    bwd_vld = bvld;
    bwd_dat = bdat;
    exp_en  = xen;
    exp_val = xval;
    @(negedge aixh_core_clk2x);
  endtask

  task automatic idle_beat();                           // Random junk, all gated off
    logic [31:0] c;
    c = rand_bits(5);
    apply_beat(2'b00, c[4:0], rand_bits(32), fwd_dat_t'(rand_bits(16)), 1'b0, rand_bits(32),
               1'b0, '0);
  endtask

  task automatic cmd_beat(input logic [1:0] vld, input ipcell_cmd_t cmd, input logic xen,
                          input acc_t xval);
    apply_beat(vld, cmd, '0, '0, 1'b0, '0, xen, xval);
  endtask

  task automatic data_beat(input int i);
    logic [31:0] r;
    r      = rand_bits(32);
    ty0[i] = r[7:0];
    ty1[i] = r[15:8];
    ty2[i] = r[23:16];
    ty3[i] = r[31:24];
    r      = rand_bits(16);
    tx0[i] = r[7:0];
    tx1[i] = r[15:8];
    apply_beat(2'b01, mk_cmd(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), {ty3[i], ty2[i], ty1[i], ty0[i]},
               {tx1[i], tx0[i]}, 1'b0, '0, 1'b0, '0);
  endtask

  // Afresh, K data, flush, gated commands, drain lane0, move, drain lane1
  task automatic run_tile(input int k);
    acc_t lane0;
    acc_t lane1;
    cmd_beat(2'b01, mk_cmd(1'b0, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0, '0);
    for (int i = 0; i < k; i++) data_beat(i);
    for (int i = 0; i < FLUSH; i++) cmd_beat(2'b01, mk_cmd(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), 1'b0, '0);
    lane0 = ref_lane_sum(0, k);
    lane1 = ref_lane_sum(1, k);
    // Commands on the wrong valid leave both sums and the chain alone
    cmd_beat(2'b10, mk_cmd(1'b0, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0, '0);   // Afresh without vld[0]
    cmd_beat(2'b01, mk_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0, '0);   // Drain without vld[1]
    cmd_beat(2'b01, mk_cmd(1'b0, 1'b1, 1'b0, 1'b1, 1'b0), 1'b0, '0);   // Move without vld[1]
    cmd_beat(2'b10, mk_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), 1'b1, lane0);
    cmd_beat(2'b11, mk_cmd(1'b0, 1'b1, 1'b0, 1'b1, 1'b0), 1'b0, '0);
    cmd_beat(2'b10, mk_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), 1'b1, lane1);
    idle_beat();
    idle_beat();
  endtask

  // ------------------------------------------------------------
  // Monitor, expected state follows the inputs at each rising edge
  // ------------------------------------------------------------
  always @(posedge aixh_core_clk2x) begin
    if (rst) begin
      rec_active = 1'b0;
      rec_vld    = 2'b00;
      rec_cmd    = '0;
      drain_d1   = 1'b0;
      rec_bvld   = 1'b0;
    end else begin
      rec_active = 1'b1;
      rec_vld    = dwd_vld;                             // Neighbour outputs, one cycle
      rec_cmd    = expect_gated(fwd_cmd, dwd_vld);
      if (dwd_vld[0]) begin
        rec_dwd   = dwd_dat;
        rec_fwd   = fwd_dat;
        dat_known = 1'b1;
      end
      rec_bvld   = drain_d1 | bwd_vld;                  // Drain two cycles, pass-through one
      drain_d1   = dwd_vld[1] & fwd_cmd.drain_req1;
      if (exp_en) exp_q.push_back(exp_val);
      cycles += 1;
      if (cycles > limit) begin
        report_problem("timeout, stimulus did not complete within the cycle limit");
        finish_run();
      end
    end
  end

  // Compare, outputs are stable at the falling edge
  always @(negedge aixh_core_clk2x) begin
    acc_t want;
    if (rec_active) begin
      checks += 1;
      assert (o_dwd_vld == rec_vld)
        else report_mismatch("o_dwd_vld", {30'd0, rec_vld}, {30'd0, o_dwd_vld});
      assert (o_fwd_cmd == rec_cmd)
        else report_mismatch("o_fwd_cmd", {27'd0, rec_cmd}, {27'd0, o_fwd_cmd});
      if (dat_known) begin
        assert (o_dwd_dat == rec_dwd) else report_mismatch("o_dwd_dat", rec_dwd, o_dwd_dat);
        assert (o_fwd_dat == rec_fwd)
          else report_mismatch("o_fwd_dat", {16'd0, rec_fwd}, {16'd0, o_fwd_dat});
      end
      assert (o_bwd_vld == rec_bvld)
        else report_mismatch("o_bwd_vld", {31'd0, rec_bvld}, {31'd0, o_bwd_vld});
      if (rec_bvld) begin
        if (exp_q.size() == 0) begin
          report_problem("backward chain output with no result queued");
        end else begin
          want = exp_q.pop_front();
          if (o_bwd_vld) begin
            assert (o_bwd_dat == want) else report_mismatch("o_bwd_dat", want, o_bwd_dat);
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    int   k_list [NUM_TILES];
    lfsr       = LFSR_SEED;
    dwd_vld    = 2'b00;
    dwd_dat    = '0;
    fwd_cmd    = '0;
    fwd_dat    = '0;
    bwd_vld    = 1'b0;
    bwd_dat    = '0;
    exp_en     = 1'b0;
    exp_val    = '0;
    rec_active = 1'b0;
    dat_known  = 1'b0;
    cycles     = 0;
    checks     = 0;
    errors     = 0;
    limit      = 11 + 50;                               // Priority, tail, first cycle, margin
    for (int t = 0; t < NUM_TILES; t++) begin
      k_list[t] = 1 + int'(rand_bits(4));               // K from 1 to 16
      limit    += k_list[t] + FLUSH + 9;
    end

    @(negedge aixh_core_clk2x);
    while (rst) @(negedge aixh_core_clk2x);
    assert (o_dwd_vld == 2'b00) else report_mismatch("o_dwd_vld", '0, {30'd0, o_dwd_vld});
    assert (o_fwd_cmd == '0) else report_mismatch("o_fwd_cmd", '0, {27'd0, o_fwd_cmd});
    assert (o_bwd_vld == 1'b0) else report_mismatch("o_bwd_vld", '0, {31'd0, o_bwd_vld});

    for (int t = 0; t < NUM_TILES; t++) run_tile(k_list[t]);

    // Neighbour data overtakes a local drain, then a lone pass-through
    cmd_beat(2'b10, mk_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0, '0);
    apply_beat(2'b00, '0, '0, '0, 1'b1, 32'h1234_5678, 1'b1, 32'h1234_5678);
    idle_beat();
    idle_beat();
    apply_beat(2'b00, '0, '0, '0, 1'b1, 32'h8765_4321, 1'b1, 32'h8765_4321);
    idle_beat();
    idle_beat();

    idle_beat();
    idle_beat();
    idle_beat();
    if (exp_q.size() != 0) report_problem("expected backward chain results never appeared");
    finish_run();
  end

endmodule

// File: filelist.f
+incdir+source
source/ipcell_cmd_pkg.sv
source/ipcell_num_pkg.sv
source/ipcell_op_if.sv
source/ipcell_fwd_stage.sv
source/ipcell_mul_pair.sv
source/ipcell_accum_drain.sv
source/ipcell_top.sv
verif/tb_clk_gen.sv
verif/tb_ipcell.sv

// File: Makefile
TOP := tb_ipcell

all: run

obj_dir/V$(TOP): filelist.f $(wildcard source/*) $(wildcard verif/*)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "No pass line in sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert +incdir+source --top-module ipcell_top \
	  source/ipcell_cmd_pkg.sv source/ipcell_num_pkg.sv source/ipcell_op_if.sv \
	  source/ipcell_fwd_stage.sv source/ipcell_mul_pair.sv source/ipcell_accum_drain.sv \
	  source/ipcell_top.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
